// File: design/plot_pkg.sv
`default_nettype none

package plot_pkg;

	// 160x120 frame buffer coordinates
	typedef logic [7:0] screen_x_t; // column 0..159
	typedef logic [6:0] screen_y_t; // row 0..119

	// one bit each of red, green and blue
	typedef logic [2:0] colour_t;

	// one write into the frame buffer
	// 8 + 7 + 3 = 18 bits
	typedef struct packed {
		screen_x_t x;
		screen_y_t y;
		colour_t   colour;
	} plot_pixel_t;

endpackage

`default_nettype wire

// File: design/sprite_pkg.sv
`default_nettype none

package sprite_pkg;

	// glyph sizes in pixels
	localparam int DIGIT_W = 6;
	localparam int DIGIT_H = 10;
	localparam int LEVEL_W = 38;
	localparam int LEVEL_H = 10;

	// one colour word per glyph pixel
	localparam int DIGIT_WORDS = DIGIT_W * DIGIT_H; // 60
	localparam int LEVEL_WORDS = LEVEL_W * LEVEL_H; // 380

	typedef logic [3:0] digit_t;      // values above 9 draw blank
	typedef logic [5:0] glyph_col_t;  // sized for the label
	typedef logic [3:0] glyph_row_t;
	typedef logic [8:0] glyph_addr_t; // word within one glyph

	// which object an item belongs to
	typedef enum logic [1:0] {
		OBJ_NONE  = 2'd0, // bubble
		OBJ_DIGIT = 2'd1,
		OBJ_LABEL = 2'd2
	} obj_kind_t;

	// one pixel request from the scanner
	// 2 + 6 + 4 + 9 = 21 bits
	typedef struct packed {
		obj_kind_t   kind;
		glyph_col_t  col;
		glyph_row_t  row;
		glyph_addr_t addr;
	} scan_item_t;

endpackage

`default_nettype wire

// File: design/sprite_scanner.sv
`default_nettype none

module sprite_scanner
(
	input  logic                   CLOCK_50,
	input  logic                   reset,
	output sprite_pkg::scan_item_t scan
);
	import sprite_pkg::*;

	obj_kind_t   obj;
	obj_kind_t   obj_next;
	glyph_col_t  col;
	glyph_col_t  col_next;
	glyph_row_t  row;
	glyph_row_t  row_next;
	glyph_addr_t addr;
	glyph_addr_t addr_next;

	glyph_col_t  last_col;
	glyph_row_t  last_row;
	glyph_addr_t last_addr;
	logic        end_of_row;
	logic        end_of_glyph;

	// limits of the glyph being walked
	// idle has all limits at zero so its single item wraps everything
	always_comb
	begin
		case (obj)
			OBJ_DIGIT:
			begin
				last_col  = glyph_col_t'(DIGIT_W - 1);
				last_row  = glyph_row_t'(DIGIT_H - 1);
				last_addr = glyph_addr_t'(DIGIT_WORDS - 1);
			end
			OBJ_LABEL:
			begin
				last_col  = glyph_col_t'(LEVEL_W - 1);
				last_row  = glyph_row_t'(LEVEL_H - 1);
				last_addr = glyph_addr_t'(LEVEL_WORDS - 1);
			end
			default:
			begin
				last_col  = '0;
				last_row  = '0;
				last_addr = '0;
			end
		endcase
	end

	assign end_of_row   = (col == last_col);
	assign end_of_glyph = end_of_row && (row == last_row);

	// column counts fastest
	always_comb
	begin
		col_next  = col + 1'b1;
		row_next  = row;
		addr_next = addr + 1'b1;

		if (end_of_row)
		begin
			col_next = '0;
			row_next = row + 1'b1;
			if (row == last_row)
				row_next = '0;
		end

		if (addr == last_addr)
			addr_next = '0; // last word of the glyph
	end

	// idle, then digit, then label, then idle again
	always_comb
	begin
		case (obj)
			OBJ_NONE:
				obj_next = OBJ_DIGIT; // one idle cycle only
			OBJ_DIGIT:
			begin
				if (end_of_glyph)
					obj_next = OBJ_LABEL;
				else
					obj_next = OBJ_DIGIT;
			end
			OBJ_LABEL:
			begin
				if (end_of_glyph)
					obj_next = OBJ_NONE;
				else
					obj_next = OBJ_LABEL;
			end
			default:
				obj_next = OBJ_NONE;
		endcase
	end

	always_ff @(posedge CLOCK_50)
	begin
		if (!reset)
		begin
			obj  <= OBJ_NONE;
			col  <= '0;
			row  <= '0;
			addr <= '0;
		end
		else
		begin
			obj  <= obj_next;
			col  <= col_next;
			row  <= row_next;
			addr <= addr_next;
		end
	end

	// item goes out in the same cycle as the state that names it
	always_comb
	begin
		scan.kind = obj;
		scan.col  = col;
		scan.row  = row;
		scan.addr = addr;
	end

endmodule

`default_nettype wire

// File: design/glyph_rom.sv
`default_nettype none

module glyph_rom
(
	input  logic                   CLOCK_50,
	input  logic                   reset,
	input  sprite_pkg::digit_t     level,
	input  sprite_pkg::scan_item_t scan,
	output sprite_pkg::scan_item_t scan_q,
	output plot_pkg::colour_t      pixel_colour
);
	import sprite_pkg::*;
	import plot_pkg::*;

	localparam int    DIGIT_COUNT     = 10;
	localparam int    DIGIT_MEM_WORDS = DIGIT_COUNT * DIGIT_WORDS; // 600
	localparam int    DIGIT_INDEX_W   = $clog2(DIGIT_MEM_WORDS);
	localparam string LEVEL_FILE      = "design/level_glyph.mem";
	localparam string DIGIT_FILE      = "design/digit_glyphs.mem";

	colour_t level_mem [LEVEL_WORDS];
	colour_t digit_mem [DIGIT_MEM_WORDS]; // digit n starts at word n*60

	digit_t                   digit_q;
	logic                     digit_ok;
	logic [DIGIT_INDEX_W-1:0] digit_index;

	colour_t level_word;
	colour_t digit_word;
	logic    digit_blank;

	initial
	begin
		$readmemh(LEVEL_FILE, level_mem);
		$readmemh(DIGIT_FILE, digit_mem);
	end

	// digit is taken on the idle item, so it holds for a whole frame
	always_ff @(posedge CLOCK_50)
	begin
		if (!reset)
			digit_q <= 4'hf; // invalid until first frame
		else if (scan.kind == OBJ_NONE)
			digit_q <= level;
	end

	assign digit_ok = (digit_q < DIGIT_COUNT);

	// stay inside the digit memory for label items and bad digits
	always_comb
	begin
		digit_index = '0;
		if (digit_ok && (scan.kind == OBJ_DIGIT))
			digit_index = DIGIT_INDEX_W'(digit_q * DIGIT_WORDS + scan.addr);
	end

	// synchronous reads
	always_ff @(posedge CLOCK_50)
	begin
		level_word  <= level_mem[scan.addr];
		digit_word  <= digit_mem[digit_index];
		digit_blank <= !digit_ok;
	end

	// item travels alongside its read word
	always_ff @(posedge CLOCK_50)
	begin
		if (!reset)
			scan_q <= '0; // kind none
		else
			scan_q <= scan;
	end

	always_comb
	begin
		case (scan_q.kind)
			OBJ_DIGIT:
			begin
				if (digit_blank)
					pixel_colour = '0;
				else
					pixel_colour = digit_word;
			end
			OBJ_LABEL:
				pixel_colour = level_word;
			default:
				pixel_colour = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: design/plot_writer.sv
`default_nettype none

module plot_writer
#(
	parameter plot_pkg::screen_x_t LEVEL_X0 = 8'd57,
	parameter plot_pkg::screen_x_t DIGIT_X0 = 8'd97,
	parameter plot_pkg::screen_y_t TOP_Y    = 7'd20
)
(
	input  logic                   CLOCK_50,
	input  logic                   reset,
	input  sprite_pkg::scan_item_t scan_q,
	input  plot_pkg::colour_t      pixel_colour,
	output logic                   plot,
	output plot_pkg::plot_pixel_t  pixel
);
	import sprite_pkg::*;
	import plot_pkg::*;

	screen_x_t   x_origin;
	logic        item_valid;
	plot_pixel_t pixel_next;

	// both glyphs share one top row
	always_comb
	begin
		case (scan_q.kind)
			OBJ_DIGIT: x_origin = DIGIT_X0;
			default:   x_origin = LEVEL_X0;
		endcase
	end

	assign item_valid = (scan_q.kind != OBJ_NONE);

	always_comb
	begin
		pixel_next = '0; // bubbles give an all-zero pixel
		if (item_valid)
		begin
			pixel_next.x      = x_origin + screen_x_t'(scan_q.col);
			pixel_next.y      = TOP_Y + screen_y_t'(scan_q.row);
			pixel_next.colour = pixel_colour;
		end
	end

	always_ff @(posedge CLOCK_50)
	begin
		if (!reset)
		begin
			plot  <= 1'b0;
			pixel <= '0;
		end
		else
		begin
			plot  <= item_valid;
			pixel <= pixel_next;
		end
	end

endmodule

`default_nettype wire

// File: design/level_display.sv
`default_nettype none

module level_display
#(
	parameter plot_pkg::screen_x_t LEVEL_X0 = 8'd57,
	parameter plot_pkg::screen_x_t DIGIT_X0 = 8'd97, // right of the label
	parameter plot_pkg::screen_y_t TOP_Y    = 7'd20
)
(
	input  logic                  CLOCK_50,
	input  logic                  reset,
	input  sprite_pkg::digit_t    level,
	output logic                  plot,
	output plot_pkg::plot_pixel_t pixel
);
	import sprite_pkg::*;
	import plot_pkg::*;

	scan_item_t scan;         // scanner to memories
	scan_item_t scan_q;       // one cycle later
	colour_t    pixel_colour;

	sprite_scanner scanner0
	(
		.CLOCK_50 (CLOCK_50),
		.reset    (reset),
		.scan     (scan)
	);

	glyph_rom rom0
	(
		.CLOCK_50     (CLOCK_50),
		.reset        (reset),
		.level        (level),
		.scan         (scan),
		.scan_q       (scan_q),
		.pixel_colour (pixel_colour)
	);

	plot_writer
	#(
		.LEVEL_X0 (LEVEL_X0),
		.DIGIT_X0 (DIGIT_X0),
		.TOP_Y    (TOP_Y)
	)
	writer0
	(
		.CLOCK_50     (CLOCK_50),
		.reset        (reset),
		.scan_q       (scan_q),
		.pixel_colour (pixel_colour),
		.plot         (plot),
		.pixel        (pixel)
	);

endmodule

`default_nettype wire

// File: test/level_display_tb.sv
`default_nettype none

module level_display_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import sprite_pkg::*;
	import plot_pkg::*;

	localparam int FRAME_PIXELS = DIGIT_WORDS + LEVEL_WORDS; // 440 pixels then one gap
	localparam int DIGIT_LEFT   = 97;
	localparam int LABEL_LEFT   = 57;
	localparam int GLYPH_TOP    = 20;
	localparam int FRAMES       = 8;
	localparam int MID_FRAME    = 30; // level changes while the digit is drawn
	localparam int RISE_LIMIT   = 20;
	localparam int SEED         = 41175;

	logic        CLOCK_50;
	logic        reset;
	digit_t      level;
	logic        plot;
	plot_pixel_t pixel;

	colour_t label_ref [LEVEL_WORDS];
	colour_t digit_ref [10 * DIGIT_WORDS];

	// reference frame position
	logic        prev_reset_low;
	logic        tracking;
	int          out_idx;
	int          exp_idx;
	logic        active;
	digit_t      frame_level;
	plot_pixel_t exp_pixel;

	level_display dut0
	(
		.CLOCK_50 (CLOCK_50),
		.reset    (reset),
		.level    (level),
		.plot     (plot),
		.pixel    (pixel)
	);

	always #5 CLOCK_50 = ~CLOCK_50;

	task automatic abort_run();
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_mismatch(input string msg);
		$display("** Error at %0d ns: %s", $time, msg);
		abort_run();
	endtask

	task automatic next_cycle();
		@(posedge CLOCK_50);
		#1;
	endtask

	// poll plot just after each edge for up to limit cycles
	task automatic wait_plot(input logic value, input int limit, input string what);
		int count;
		count = 0;
		while (plot !== value && count < limit)
		begin
			next_cycle();
			count++;
		end
		if (plot !== value)
		begin
			$display("timed out after %0d cycles waiting for %s", limit, what);
			abort_run();
		end
	endtask

	// some frames get a digit outside 0..9
	function automatic digit_t pick_level(input int frame);
		if (frame == 2 || frame == 5)
			return digit_t'($urandom_range(15, 10));
		return digit_t'($urandom_range(9, 0));
	endfunction

	// where the n-th pixel of a frame goes and what colour it has
	function automatic plot_pixel_t expected_pixel(input int idx, input digit_t dig);
		plot_pixel_t p;
		int          m;
		p = '0;
		if (idx < DIGIT_WORDS)
		begin
			p.x = screen_x_t'(DIGIT_LEFT + idx % DIGIT_W);
			p.y = screen_y_t'(GLYPH_TOP + idx / DIGIT_W);
			if (dig <= 4'd9)
				p.colour = digit_ref[int'(dig) * DIGIT_WORDS + idx];
		end
		else if (idx < FRAME_PIXELS)
		begin
			m = idx - DIGIT_WORDS;
			p.x      = screen_x_t'(LABEL_LEFT + m % LEVEL_W);
			p.y      = screen_y_t'(GLYPH_TOP + m / LEVEL_W);
			p.colour = label_ref[m];
		end
		return p;
	endfunction

	assign exp_idx = tracking ? out_idx : 0;
	assign active  = reset && (tracking || plot);

	always_comb
		exp_pixel = expected_pixel(exp_idx, frame_level);

	// frame counter starts on the first pixel seen
	always @(posedge CLOCK_50)
	begin
		prev_reset_low <= !reset;
		if (!reset)
		begin
			tracking    <= 1'b0;
			out_idx     <= 0;
			frame_level <= level;
		end
		else if (active)
		begin
			tracking <= 1'b1;
			if (exp_idx == FRAME_PIXELS)
			begin
				out_idx     <= 0;
				frame_level <= level; // held through the idle cycle
			end
			else
				out_idx <= exp_idx + 1;
		end
	end

	reset_quiet: assert property (@(posedge CLOCK_50)
		prev_reset_low |-> (!plot && pixel == '0))
		else report_mismatch("plot or pixel active in or right after reset");

	frame_body: assert property (@(posedge CLOCK_50) disable iff (!reset)
		(tracking && out_idx < FRAME_PIXELS) |-> plot)
		else report_mismatch($sformatf("plot low at frame pixel %0d", $sampled(out_idx)));

	frame_gap: assert property (@(posedge CLOCK_50) disable iff (!reset)
		(tracking && out_idx == FRAME_PIXELS) |-> (!plot && pixel == '0))
		else report_mismatch("frame gap missing or pixel not zero in the gap");

	digit_place: assert property (@(posedge CLOCK_50) disable iff (!reset)
		(active && exp_idx < DIGIT_WORDS) |->
		(pixel.x == exp_pixel.x && pixel.y == exp_pixel.y))
		else report_mismatch($sformatf("digit pixel %0d at wrong place", $sampled(exp_idx)));

	digit_colour: assert property (@(posedge CLOCK_50) disable iff (!reset)
		(active && exp_idx < DIGIT_WORDS) |-> (pixel.colour == exp_pixel.colour))
		else report_mismatch($sformatf("digit pixel %0d has wrong colour for digit %0d",
			$sampled(exp_idx), $sampled(frame_level)));

	label_place: assert property (@(posedge CLOCK_50) disable iff (!reset)
		(active && exp_idx >= DIGIT_WORDS && exp_idx < FRAME_PIXELS) |->
		(pixel.x == exp_pixel.x && pixel.y == exp_pixel.y))
		else report_mismatch($sformatf("label pixel %0d at wrong place", $sampled(exp_idx)));

	label_colour: assert property (@(posedge CLOCK_50) disable iff (!reset)
		(active && exp_idx >= DIGIT_WORDS && exp_idx < FRAME_PIXELS) |->
		(pixel.colour == exp_pixel.colour))
		else report_mismatch($sformatf("label pixel %0d has wrong colour", $sampled(exp_idx)));

	initial
	begin
		void'($urandom(SEED));
		$readmemh("design/level_glyph.mem", label_ref);
		$readmemh("design/digit_glyphs.mem", digit_ref);

		CLOCK_50       = 1'b0;
		reset          = 1'b0;
		level          = digit_t'($urandom_range(9, 0));
		prev_reset_low = 1'b0;
		tracking       = 1'b0;
		out_idx        = 0;
		frame_level    = '0;

		repeat (5) @(posedge CLOCK_50);
		#1 reset = 1'b1;

		wait_plot(1'b1, RISE_LIMIT, "the first pixel");
		for (int f = 0; f < FRAMES; f++)
		begin
			repeat (MID_FRAME) next_cycle();
			level = pick_level(f); // current frame keeps its old digit
			wait_plot(1'b0, FRAME_PIXELS + 5, "the frame gap");
			wait_plot(1'b1, 5, "the next frame");
		end

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: design/level_glyph.mem
// label glyph colours, row-major, one glyph row per line (rows 0 to 9)
// columns are x 0 to 37 of the row, one 3-bit colour per hex word
6 6 0 0 0 0 0 0 3 3 3 3 3 3 0 0 5 5 0 0 5 5 0 0 3 3 3 3 3 3 0 0 6 6 0 0 0 0
6 6 0 0 0 0 0 0 3 3 3 3 3 3 0 0 5 5 0 0 5 5 0 0 3 3 3 3 3 3 0 0 6 6 0 0 0 0
6 6 0 0 0 0 0 0 3 3 0 0 0 0 0 0 5 5 0 0 5 5 0 0 3 3 0 0 0 0 0 0 6 6 0 0 0 0
6 6 0 0 0 0 0 0 3 3 0 0 0 0 0 0 5 5 0 0 5 5 0 0 3 3 0 0 0 0 0 0 6 6 0 0 0 0
6 6 0 0 0 0 0 0 3 3 3 3 3 0 0 0 5 5 0 0 5 5 0 0 3 3 3 3 3 0 0 0 6 6 0 0 0 0
6 6 0 0 0 0 0 0 3 3 3 3 3 0 0 0 5 5 0 0 5 5 0 0 3 3 3 3 3 0 0 0 6 6 0 0 0 0
6 6 0 0 0 0 0 0 3 3 0 0 0 0 0 0 0 5 5 5 5 0 0 0 3 3 0 0 0 0 0 0 6 6 0 0 0 0
6 6 0 0 0 0 0 0 3 3 0 0 0 0 0 0 0 5 5 5 5 0 0 0 3 3 0 0 0 0 0 0 6 6 0 0 0 0
6 6 6 6 6 6 0 0 3 3 3 3 3 3 0 0 0 0 5 5 0 0 0 0 3 3 3 3 3 3 0 0 6 6 6 6 6 6
6 6 6 6 6 6 0 0 3 3 3 3 3 3 0 0 0 0 5 5 0 0 0 0 3 3 3 3 3 3 0 0 6 6 6 6 6 6

// File: design/digit_glyphs.mem
// digit glyph colours, one digit per line, digits 0 to 9 in order
// each line holds glyph rows 0 to 9 of six columns each, row-major, one colour per word
1 1 1 1 1 1 1 1 0 0 1 1 1 1 0 0 1 1 1 1 0 0 1 1 1 1 0 0 1 1 1 1 0 0 1 1 1 1 0 0 1 1 1 1 0 0 1 1 1 1 0 0 1 1 1 1 1 1 1 1
0 0 0 0 2 2 0 0 0 0 2 2 0 0 0 0 2 2 0 0 0 0 2 2 0 0 0 0 2 2 0 0 0 0 2 2 0 0 0 0 2 2 0 0 0 0 2 2 0 0 0 0 2 2 0 0 0 0 2 2
3 3 3 3 3 3 0 0 0 0 3 3 0 0 0 0 3 3 0 0 0 0 3 3 0 0 0 0 3 3 3 3 3 3 3 3 3 3 0 0 0 0 3 3 0 0 0 0 3 3 0 0 0 0 3 3 3 3 3 3
4 4 4 4 4 4 0 0 0 0 4 4 0 0 0 0 4 4 0 0 0 0 4 4 0 0 0 0 4 4 4 4 4 4 4 4 0 0 0 0 4 4 0 0 0 0 4 4 0 0 0 0 4 4 4 4 4 4 4 4
5 5 0 0 5 5 5 5 0 0 5 5 5 5 0 0 5 5 5 5 0 0 5 5 5 5 0 0 5 5 5 5 5 5 5 5 0 0 0 0 5 5 0 0 0 0 5 5 0 0 0 0 5 5 0 0 0 0 5 5
6 6 6 6 6 6 6 6 0 0 0 0 6 6 0 0 0 0 6 6 0 0 0 0 6 6 0 0 0 0 6 6 6 6 6 6 0 0 0 0 6 6 0 0 0 0 6 6 0 0 0 0 6 6 6 6 6 6 6 6
7 7 7 7 7 7 7 7 0 0 0 0 7 7 0 0 0 0 7 7 0 0 0 0 7 7 0 0 0 0 7 7 7 7 7 7 7 7 0 0 7 7 7 7 0 0 7 7 7 7 0 0 7 7 7 7 7 7 7 7
1 1 1 1 1 1 0 0 0 0 1 1 0 0 0 0 1 1 0 0 0 0 1 1 0 0 0 0 1 1 0 0 0 0 1 1 0 0 0 0 1 1 0 0 0 0 1 1 0 0 0 0 1 1 0 0 0 0 1 1
2 2 2 2 2 2 2 2 0 0 2 2 2 2 0 0 2 2 2 2 0 0 2 2 2 2 0 0 2 2 2 2 2 2 2 2 2 2 0 0 2 2 2 2 0 0 2 2 2 2 0 0 2 2 2 2 2 2 2 2
3 3 3 3 3 3 3 3 0 0 3 3 3 3 0 0 3 3 3 3 0 0 3 3 3 3 0 0 3 3 3 3 3 3 3 3 0 0 0 0 3 3 0 0 0 0 3 3 0 0 0 0 3 3 3 3 3 3 3 3

// File: files.f
design/plot_pkg.sv
design/sprite_pkg.sv
design/sprite_scanner.sv
design/glyph_rom.sv
design/plot_writer.sv
design/level_display.sv
test/level_display_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the level display testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--timescale 1ns/1ps \
	--top-module level_display_tb \
	-f files.f \
	-o level_display_sim

# $fatal gives a non-zero exit status
./obj_dir/level_display_sim
